// File: verilog/wisc_consts.svh
// widths, depths and APB address map of the WISC execution subsystem
`ifndef WISC_CONSTS_SVH
`define WISC_CONSTS_SVH

`define WISC_XLEN          16      // data word width
`define WISC_NREGS         8       // register file entries
`define WISC_QUEUE_DEPTH   4       // instruction queue entries
`define WISC_DMEM_WORDS    16      // data memory words, low addr bits only

`define WISC_APB_AW        8       // APB address width
`define WISC_APB_DW        32      // APB data width

`define WISC_ADDR_INSTR    8'h00   // write only, pushes one instruction
`define WISC_ADDR_STATUS   8'h04   // read only, {err, halted, busy}
`define WISC_ADDR_CTRL     8'h08   // bit 0 clears halted and err
`define WISC_ADDR_REG_BASE 8'h20   // register n at base + 4*n

`endif

// File: verilog/wiscPkg.sv
// opcode enum, instruction word union, control struct and APB request struct
`default_nettype none
`include "wisc_consts.svh"

package wiscPkg;

   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000, OP_NOP   = 5'b00001, OP_SIIC  = 5'b00010, OP_RTI   = 5'b00011,
      OP_J     = 5'b00100, OP_JR    = 5'b00101, OP_JAL   = 5'b00110, OP_JALR  = 5'b00111,
      OP_ADDI  = 5'b01000, OP_SUBI  = 5'b01001, OP_XORI  = 5'b01010, OP_ANDNI = 5'b01011,
      OP_BEQZ  = 5'b01100, OP_BNEZ  = 5'b01101, OP_BLTZ  = 5'b01110, OP_BGEZ  = 5'b01111,
      OP_ST    = 5'b10000, OP_LD    = 5'b10001, OP_SLBI  = 5'b10010, OP_STU   = 5'b10011,
      OP_ROLI  = 5'b10100, OP_SLLI  = 5'b10101, OP_RORI  = 5'b10110, OP_SRLI  = 5'b10111,
      OP_LBI   = 5'b11000, OP_BTR   = 5'b11001, OP_SHIFT = 5'b11010, OP_ARITH = 5'b11011,
      OP_SEQ   = 5'b11100, OP_SLT   = 5'b11101, OP_SLE   = 5'b11110, OP_SCO   = 5'b11111
   } opcode_t;

   // one 16-bit word, four views
   typedef union packed {
      struct packed {
         opcode_t    op;
         logic [2:0] rs;
         logic [2:0] rt;
         logic [2:0] rd;       // R-format destination
         logic [1:0] func;     // selects op within a group
      } rForm;
      struct packed {
         opcode_t    op;
         logic [2:0] rs;
         logic [2:0] rd;       // same bits as rt
         logic [4:0] imm5;
      } iForm1;
      struct packed {
         opcode_t    op;
         logic [2:0] rs;
         logic [7:0] imm8;
      } iForm2;
      struct packed {
         opcode_t     op;
         logic [10:0] disp11;  // PC-relative, no PC here
      } jForm;
   } instrWord_t;

   typedef struct packed {
      logic       memWrt;
      logic       regWrt;
      logic       Cin;
      logic       invA;
      logic       invB;
      logic       stuSel;      // mem write data from rt
      logic       zeroSel;     // zero extend immediates
      logic       sOpSel;      // set-condition result to wb
      logic       aluPC;
      logic       jalSel;
      logic       immSrc;
      logic       SLBIsel;     // wb 00 picks SLBI over bit reverse
      logic       createDump;  // HALT
      logic [1:0] wbDataSel;   // 00 slbi/btr, 01 mem, 10 alu/set, 11 imm8
      logic [1:0] BSrc;        // 00 rt, 01 imm5, 10 imm8, 11 zero
      logic [1:0] regDestSel;  // 00 rs, 01 i-form rd, 10 r-form rd, 11 r7
      logic [2:0] brchSig;     // {sign, zero, carry}
   } ctrlSig_t;

   typedef struct packed {
      logic                     psel;
      logic                     penable;
      logic                     pwrite;
      logic [`WISC_APB_AW-1:0] paddr;
      logic [`WISC_APB_DW-1:0] pwdata;
   } apbReq_t;

endpackage

`default_nettype wire

// File: verilog/instrApbPort.sv
// APB slave: instruction push with back-pressure, status and register reads, resume
`default_nettype none
`include "wisc_consts.svh"

module instrApbPort import wiscPkg::*; (
   input  logic                          clk,
   input  logic                          arstN,
   input  apbReq_t                       apb,
   output logic [`WISC_APB_DW-1:0]       prdata,
   output logic                          pready,
   output logic                          pslverr,
   output logic                          pushValid,
   input  logic                          pushReady,
   output instrWord_t                    pushWord,
   input  logic                          halted,
   input  logic                          err,
   input  logic                          busy,
   output logic [$clog2(`WISC_NREGS)-1:0] dbgIdx,
   input  logic [`WISC_XLEN-1:0]         dbgData,
   output logic                          resume
);

   localparam int IW = $clog2(`WISC_NREGS);

   logic                    access;
   logic                    isInstr;
   logic                    isStatus;
   logic                    isCtrl;
   logic                    isReg;
   logic                    badAddr;
   logic [`WISC_APB_AW-1:0] regOff;

   assign access   = apb.psel && apb.penable;   // APB access phase
   assign isInstr  = apb.paddr == `WISC_ADDR_INSTR;
   assign isStatus = apb.paddr == `WISC_ADDR_STATUS;
   assign isCtrl   = apb.paddr == `WISC_ADDR_CTRL;

   // register window, word aligned, index bounded by NREGS
   assign regOff = apb.paddr - `WISC_ADDR_REG_BASE;
   assign isReg  = (apb.paddr >= `WISC_ADDR_REG_BASE) && (regOff[1:0] == 2'b00) &&
                   (regOff[`WISC_APB_AW-1:2] < `WISC_NREGS);
   assign dbgIdx = regOff[IW+1:2];             // only meaningful when isReg

   assign pushValid = access && apb.pwrite && isInstr;
   assign pushWord  = apb.pwdata[`WISC_XLEN-1:0];

   // instr writes wait for queue room, everything else is zero-wait
   assign pready = access && (!pushValid || pushReady);

   // writes only to INSTR/CTRL, reads only from STATUS/regs
   assign badAddr = apb.pwrite ? !(isInstr || isCtrl) : !(isStatus || isReg);
   assign pslverr = access && badAddr;

   always_comb begin
      prdata = '0;
      if (access && !apb.pwrite) begin
         if (isStatus) begin
            prdata[2:0] = {err, halted, busy};
         end else if (isReg) begin
            prdata[`WISC_XLEN-1:0] = dbgData;
         end
      end
   end

   // one-cycle pulse the edge after the CTRL write completes
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         resume <= 1'b0;
      end else begin
         resume <= access && apb.pwrite && isCtrl && apb.pwdata[0];
      end
   end

endmodule

`default_nettype wire

// File: verilog/instrQueue.sv
// show-ahead circular FIFO of instruction words with occupancy checks
`default_nettype none
`include "wisc_consts.svh"

module instrQueue import wiscPkg::*; (
   input  logic       clk,
   input  logic       arstN,
   input  logic       pushValid,
   output logic       pushReady,
   input  instrWord_t pushWord,
   output logic       popValid,
   input  logic       popReady,
   output instrWord_t popWord
);

   localparam int PW = $clog2(`WISC_QUEUE_DEPTH);

   instrWord_t    mem [`WISC_QUEUE_DEPTH];
   logic [PW-1:0] wrPtr;
   logic [PW-1:0] rdPtr;
   logic [PW:0]   count;     // one extra bit to tell full from empty
   logic          push;
   logic          pop;

   assign pushReady = count != `WISC_QUEUE_DEPTH;
   assign popValid  = count != '0;
   assign push      = pushValid && pushReady;
   assign pop       = popValid && popReady;
   assign popWord   = mem[rdPtr];                  // head shown ahead

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wrPtr] <= pushWord;                   // write at the tail
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (push) wrPtr <= wrPtr + 1'b1;          // wraps at depth (power of 2)
         if (pop) rdPtr <= rdPtr + 1'b1;
         count <= count + (PW+1)'(push) - (PW+1)'(pop);
      end
   end

   // a push into a full queue or a pop from an empty one drives count past the depth
   aCountBound: assert property (@(posedge clk) disable iff (!arstN)
      count <= `WISC_QUEUE_DEPTH);
   // pointer distance agrees with the occupancy count
   aPtrMatch: assert property (@(posedge clk) disable iff (!arstN)
      PW'(wrPtr - rdPtr) == count[PW-1:0]);

endmodule

`default_nettype wire

// File: verilog/controlUnit.sv
// opcode decoder: control struct and unsupported-instruction flag
`default_nettype none

module controlUnit import wiscPkg::*; (
   input  instrWord_t instr,
   output ctrlSig_t   ctrl,
   output logic       illegal
);

   always_comb begin
      ctrl    = '0;
      illegal = 1'b0;
      case (instr.rForm.op)
         default: illegal = 1'b1;                  // nothing else is known
         OP_HALT: ctrl.createDump = 1'b1;
         OP_NOP: ;                                 // no effect
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
            ctrl.regWrt     = 1'b1;
            ctrl.wbDataSel  = 2'b10;               // alu
            ctrl.BSrc       = 2'b01;               // imm5
            ctrl.regDestSel = 2'b01;
            ctrl.zeroSel    = instr.rForm.op[1];   // XORI, ANDNI zero extend
            ctrl.Cin        = instr.rForm.op == OP_SUBI;
            ctrl.invA       = instr.rForm.op == OP_SUBI;   // imm - rs
            ctrl.invB       = instr.rForm.op == OP_ANDNI;
         end
         OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
            ctrl.regWrt     = 1'b1;
            ctrl.wbDataSel  = 2'b10;
            ctrl.BSrc       = 2'b01;
            ctrl.zeroSel    = 1'b1;                // shift amount unsigned
            ctrl.regDestSel = 2'b01;
         end
         OP_ST: begin
            ctrl.memWrt = 1'b1;
            ctrl.stuSel = 1'b1;                    // data from rd field
            ctrl.BSrc   = 2'b01;                   // rs + sext imm5
         end
         OP_STU: begin
            ctrl.memWrt     = 1'b1;
            ctrl.stuSel     = 1'b1;
            ctrl.BSrc       = 2'b01;
            ctrl.regWrt     = 1'b1;                // rs gets the address
            ctrl.wbDataSel  = 2'b10;
            ctrl.regDestSel = 2'b00;
         end
         OP_LD: begin
            ctrl.regWrt     = 1'b1;
            ctrl.wbDataSel  = 2'b01;               // memory
            ctrl.BSrc       = 2'b01;
            ctrl.regDestSel = 2'b01;
         end
         OP_LBI: begin
            ctrl.regWrt    = 1'b1;
            ctrl.wbDataSel = 2'b11;                // sext imm8 into rs
         end
         OP_SLBI: begin
            ctrl.regWrt    = 1'b1;
            ctrl.SLBIsel   = 1'b1;
            ctrl.BSrc      = 2'b10;                // imm8
            ctrl.zeroSel   = 1'b1;                 // OR-ed in, must not sign extend
         end
         OP_BTR: begin
            ctrl.regWrt     = 1'b1;                // wb 00 without SLBIsel
            ctrl.regDestSel = 2'b10;
         end
         OP_ARITH, OP_SHIFT: begin
            ctrl.regWrt     = 1'b1;
            ctrl.wbDataSel  = 2'b10;
            ctrl.regDestSel = 2'b10;
            if (instr.rForm.op == OP_ARITH) begin
               ctrl.Cin  = instr.rForm.func == 2'b01;  // SUB is rt - rs
               ctrl.invA = instr.rForm.func == 2'b01;
               ctrl.invB = instr.rForm.func == 2'b11;  // ANDN
            end
         end
         OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
            ctrl.regWrt     = 1'b1;
            ctrl.wbDataSel  = 2'b10;
            ctrl.sOpSel     = 1'b1;
            ctrl.regDestSel = 2'b10;
            ctrl.Cin        = instr.rForm.op != OP_SCO;  // rs - rt for compares
            ctrl.invB       = instr.rForm.op != OP_SCO;
            case (instr.rForm.op[1:0])
               2'b00:   ctrl.brchSig = 3'b010;     // zero
               2'b01:   ctrl.brchSig = 3'b100;     // less than
               2'b10:   ctrl.brchSig = 3'b110;     // less or equal
               default: ctrl.brchSig = 3'b001;     // carry out of rs + rt
            endcase
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            ctrl.BSrc = 2'b11;
            case (instr.rForm.op[1:0])
               2'b00:   ctrl.brchSig = 3'b010;
               2'b01:   ctrl.brchSig = 3'b101;
               2'b10:   ctrl.brchSig = 3'b100;
               default: ctrl.brchSig = 3'b011;
            endcase
            illegal = 1'b1;                        // no PC to branch with
         end
         OP_J, OP_JAL: begin
            ctrl.immSrc  = 1'b1;                   // disp11 to PC adder
            ctrl.jalSel  = instr.rForm.op == OP_JAL;
            ctrl.brchSig = 3'b111;
            illegal      = 1'b1;
         end
         OP_JR, OP_JALR: begin
            ctrl.aluPC   = 1'b1;                   // rs + imm8 as target
            ctrl.jalSel  = instr.rForm.op == OP_JALR;
            ctrl.BSrc    = 2'b10;
            ctrl.brchSig = 3'b111;
            illegal      = 1'b1;
         end
         OP_SIIC, OP_RTI: illegal = 1'b1;          // no exception state
      endcase
      // stores never share a word with a branch or set-condition code
      assert (!(ctrl.memWrt && ctrl.brchSig != 3'b000));
   end

endmodule

`default_nettype wire

// File: verilog/execUnit.sv
// execution unit with register file, ALU, data memory, writeback, halt and error state
`default_nettype none
`include "wisc_consts.svh"

module execUnit import wiscPkg::*; (
   input  logic                           clk,
   input  logic                           arstN,
   input  logic                           popValid,
   output logic                           popReady,
   input  instrWord_t                     popWord,
   input  logic                           resume,
   output logic                           halted,
   output logic                           err,
   input  logic [$clog2(`WISC_NREGS)-1:0] dbgIdx,
   output logic [`WISC_XLEN-1:0]          dbgData
);

   localparam int XL = `WISC_XLEN;
   localparam int MA = $clog2(`WISC_DMEM_WORDS);

   ctrlSig_t        ctrl;
   logic            illegal;
   logic            fire;
   logic            regWe;
   logic            memWe;
   logic [XL-1:0]   regFile [`WISC_NREGS];
   logic [XL-1:0]   dmem [`WISC_DMEM_WORDS];
   logic [XL-1:0]   rsVal, rtVal, bOp, aluA, aluB, aluRes, wbData;
   logic [XL-1:0]   revVal;                        // rs bit reversed
   logic [XL:0]     sum;                           // carry in bit XL
   logic [2*XL-1:0] rolTmp, rorTmp;
   logic [1:0]      aluSel;
   logic            shiftOp;
   logic            ltFlag;
   logic            setBit;
   logic [2:0]      destIdx;
   logic [MA-1:0]   memAddr;

   controlUnit ctrl_i (.instr(popWord), .ctrl(ctrl), .illegal(illegal));

   assign popReady = !halted;
   assign fire     = popValid && popReady;
   assign regWe    = fire && !illegal && ctrl.regWrt;
   assign memWe    = fire && !illegal && ctrl.memWrt;
   assign dbgData  = regFile[dbgIdx];
   assign rsVal    = regFile[popWord.rForm.rs];
   assign rtVal    = regFile[popWord.rForm.rt];    // also rd of ST/STU

   always_comb begin
      case (ctrl.BSrc)
         2'b00:   bOp = rtVal;
         2'b01:   bOp = ctrl.zeroSel ? XL'(popWord.iForm1.imm5)
                                     : XL'($signed(popWord.iForm1.imm5));
         2'b10:   bOp = ctrl.zeroSel ? XL'(popWord.iForm2.imm8)
                                     : XL'($signed(popWord.iForm2.imm8));
         default: bOp = '0;
      endcase
   end

   // ALU op from func in R groups and from low opcode bits in I groups
   always_comb begin
      shiftOp = popWord.rForm.op == OP_SHIFT || popWord.rForm.op[4:2] == 3'b101;
      if (popWord.rForm.op == OP_ARITH || popWord.rForm.op == OP_SHIFT) begin
         aluSel = popWord.rForm.func;
      end else if (popWord.rForm.op[4:2] == 3'b010 || shiftOp) begin
         aluSel = popWord.rForm.op[1:0];
      end else begin
         aluSel = 2'b00;
      end
   end

   assign aluA   = ctrl.invA ? ~rsVal : rsVal;
   assign aluB   = ctrl.invB ? ~bOp : bOp;
   assign sum    = {1'b0, aluA} + {1'b0, aluB} + (XL+1)'(ctrl.Cin);
   assign rolTmp = {rsVal, rsVal} << bOp[3:0];
   assign rorTmp = {rsVal, rsVal} >> bOp[3:0];
   assign revVal = {<<{rsVal}};

   always_comb begin
      if (shiftOp) begin
         case (aluSel)
            2'b00:   aluRes = rolTmp[2*XL-1:XL];
            2'b01:   aluRes = rsVal << bOp[3:0];
            2'b10:   aluRes = rorTmp[XL-1:0];
            default: aluRes = rsVal >> bOp[3:0];
         endcase
      end else begin
         case (aluSel)
            2'b10:   aluRes = aluA ^ aluB;
            2'b11:   aluRes = aluA & aluB;
            default: aluRes = sum[XL-1:0];         // ADD and SUB
         endcase
      end
   end

   // signed rs < rt as sign of rs - rt corrected for overflow
   assign ltFlag = sum[XL-1] ^ ((aluA[XL-1] == aluB[XL-1]) && (sum[XL-1] != aluA[XL-1]));
   assign setBit = (ctrl.brchSig[2] && ltFlag) || (ctrl.brchSig[1] && aluRes == '0) ||
                   (ctrl.brchSig[0] && sum[XL]);
   assign memAddr = aluRes[MA-1:0];

   always_comb begin
      case (ctrl.wbDataSel)
         2'b00:   wbData = ctrl.SLBIsel ? ({rsVal[7:0], 8'h00} | bOp) : revVal;
         2'b01:   wbData = dmem[memAddr];
         2'b10:   wbData = ctrl.sOpSel ? XL'(setBit) : aluRes;
         default: wbData = XL'($signed(popWord.iForm2.imm8));
      endcase
      case (ctrl.regDestSel)
         2'b00:   destIdx = popWord.rForm.rs;
         2'b01:   destIdx = popWord.iForm1.rd;
         2'b10:   destIdx = popWord.rForm.rd;
         default: destIdx = 3'd7;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         halted <= 1'b0;
         err    <= 1'b0;
         for (int i = 0; i < `WISC_NREGS; i++) regFile[i] <= '0;
         for (int i = 0; i < `WISC_DMEM_WORDS; i++) dmem[i] <= '0;
      end else begin
         if (resume) begin
            halted <= 1'b0;
            err    <= 1'b0;
         end
         if (fire && illegal) err <= 1'b1;         // sticky error and the word is dropped
         else if (fire && ctrl.createDump) halted <= 1'b1;
         if (regWe) regFile[destIdx] <= wbData;
         if (memWe) dmem[memAddr] <= ctrl.stuSel ? rtVal : aluRes;
      end
   end

   // a halted unit leaves the queue head in place
   aHaltFreeze: assert property (@(posedge clk) disable iff (!arstN)
      halted && !resume && popValid |=> popValid && $stable(popWord));
   aPcIsIllegal: assert property (@(posedge clk) disable iff (!arstN)
      popValid && (ctrl.aluPC || ctrl.jalSel || ctrl.immSrc) |-> illegal && !regWe);

endmodule

`default_nettype wire

// File: verilog/wiscCore.sv
// top level: APB port, instruction queue and execution unit
`default_nettype none
`include "wisc_consts.svh"

module wiscCore import wiscPkg::*; (
   input  logic                    clk,
   input  logic                    arstN,
   input  apbReq_t                 apb,
   output logic [`WISC_APB_DW-1:0] prdata,
   output logic                    pready,
   output logic                    pslverr
);

   logic                           pushValid, pushReady;
   logic                           popValid, popReady;
   instrWord_t                     pushWord, popWord;
   logic                           halted, err, resume;
   logic [$clog2(`WISC_NREGS)-1:0] dbgIdx;
   logic [`WISC_XLEN-1:0]          dbgData;

   instrApbPort port_i (
      .clk(clk), .arstN(arstN), .apb(apb),
      .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .pushValid(pushValid), .pushReady(pushReady), .pushWord(pushWord),
      .halted(halted), .err(err), .busy(popValid),   // busy while queue holds words
      .dbgIdx(dbgIdx), .dbgData(dbgData), .resume(resume)
   );

   instrQueue queue_i (
      .clk(clk), .arstN(arstN),
      .pushValid(pushValid), .pushReady(pushReady), .pushWord(pushWord),
      .popValid(popValid), .popReady(popReady), .popWord(popWord)
   );

   execUnit exec_i (
      .clk(clk), .arstN(arstN),
      .popValid(popValid), .popReady(popReady), .popWord(popWord),
      .resume(resume), .halted(halted), .err(err),
      .dbgIdx(dbgIdx), .dbgData(dbgData)
   );

endmodule

`default_nettype wire

// File: sim/wiscCoreTb.sv
// testbench for wiscCore: clock, reset, APB tasks, LCG, reference model, checks, sequence
`default_nettype none
`include "wisc_consts.svh"

module wiscCoreTb import wiscPkg::*; ();

   localparam int MAX_WAIT  = 40;    // cycles an APB access may wait
   localparam int MAX_POLLS = 50;    // status reads before giving up
   localparam int STALL_WIN = 12;    // cycles pready must stay low when full

   logic                    clk;
   logic                    arstN;
   apbReq_t                 apb;
   logic [`WISC_APB_DW-1:0] prdata;
   logic                    pready;
   logic                    pslverr;

   logic [15:0] mReg [8];            // reference registers
   logic [15:0] mMem [16];           // reference data memory
   logic [15:0] held [8];
   logic [31:0] lcgState;
   int          errCnt;
   int          checkCnt;
   int          testCnt;
   int          errAtStart;

   wiscCore dut_i (
      .clk(clk), .arstN(arstN), .apb(apb),
      .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

   always #50 clk = ~clk;

   // an error response is always a completed access
   aErrWithReady: assert property (@(posedge clk) disable iff (!arstN) pslverr |-> pready)
      else begin
         $display("pslverr high without pready at %0t", $time);
         errCnt++;
      end

   function automatic logic [15:0] lcgNext();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState[30:15];
   endfunction

   task automatic abortRun(input string why);
      $display("timeout: %s at %0t", why, $time);
      $display("Test failed");
      $finish;
   endtask

   task automatic checkValue(input string name, input logic [31:0] expv, input logic [31:0] got);
      checkCnt++;
      assert (got === expv) else begin
         $display("FAILED t=%0t %s expected %h got %h", $time, name, expv, got);
         errCnt++;
      end
   endtask

   // one APB transfer, setup then access until pready
   task automatic apbXfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slvErr);
      int waitCnt;
      waitCnt = 0;
      @(negedge clk);
      apb.psel    = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite  = wr;
      apb.paddr   = addr;
      apb.pwdata  = wdata;
      @(negedge clk);
      apb.penable = 1'b1;
      @(posedge clk);
      while (!pready) begin
         waitCnt++;
         if (waitCnt > MAX_WAIT) abortRun("pready never rose");
         @(posedge clk);
      end
      rdata  = prdata;
      slvErr = pslverr;
      @(negedge clk);
      apb.psel    = 1'b0;
      apb.penable = 1'b0;
   endtask

   task automatic apbWrite(input logic [7:0] addr, input logic [31:0] wdata);
      logic [31:0] rd;
      logic        se;
      apbXfer(addr, 1'b1, wdata, rd, se);
      checkValue("pslverr", 0, se);
   endtask

   task automatic apbRead(input logic [7:0] addr, output logic [31:0] rdata);
      logic se;
      apbXfer(addr, 1'b0, '0, rdata, se);
      checkValue("pslverr", 0, se);
   endtask

   function automatic logic [15:0] shiftRef(input logic [1:0] sel, input logic [15:0] v,
                                             input logic [3:0] n);
      case (sel)
         2'b00:   return (v << n) | (v >> (16 - n));   // rotate left
         2'b01:   return v << n;
         2'b10:   return (v >> n) | (v << (16 - n));   // rotate right
         default: return v >> n;
      endcase
   endfunction

   function automatic logic [15:0] reverse16(input logic [15:0] v);
      logic [15:0] r;
      for (int i = 0; i < 16; i++) r[i] = v[15-i];
      return r;
   endfunction

   // reference behavior of one instruction word
   task automatic modelExec(input logic [15:0] w);
      logic [2:0]  rs;
      logic [2:0]  rt;
      logic [2:0]  rdR;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] s5;
      logic [15:0] z5;
      logic [15:0] addr;
      logic [16:0] wide;
      rs   = w[10:8];
      rt   = w[7:5];
      rdR  = w[4:2];
      a    = mReg[rs];
      b    = mReg[rt];
      s5   = {{11{w[4]}}, w[4:0]};
      z5   = {11'b0, w[4:0]};
      addr = a + s5;
      wide = {1'b0, a} + {1'b0, b};
      case (opcode_t'(w[15:11]))
         OP_ARITH: begin
            case (w[1:0])
               2'b00:   mReg[rdR] = a + b;
               2'b01:   mReg[rdR] = b - a;
               2'b10:   mReg[rdR] = a ^ b;
               default: mReg[rdR] = a & ~b;
            endcase
         end
         OP_SHIFT: mReg[rdR] = shiftRef(w[1:0], a, b[3:0]);
         OP_ADDI:  mReg[rt] = a + s5;
         OP_SUBI:  mReg[rt] = s5 - a;
         OP_XORI:  mReg[rt] = a ^ z5;
         OP_ANDNI: mReg[rt] = a & ~z5;
         OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: mReg[rt] = shiftRef(w[12:11], a, w[3:0]);
         OP_LBI:   mReg[rs] = {{8{w[7]}}, w[7:0]};
         OP_SLBI:  mReg[rs] = (a << 8) | {8'b0, w[7:0]};
         OP_BTR:   mReg[rdR] = reverse16(a);
         OP_SEQ:   mReg[rdR] = 16'(a == b);
         OP_SLT:   mReg[rdR] = 16'($signed(a) < $signed(b));
         OP_SLE:   mReg[rdR] = 16'($signed(a) <= $signed(b));
         OP_SCO:   mReg[rdR] = 16'(wide[16]);
         OP_ST:    mMem[addr[3:0]] = b;
         OP_STU: begin
            mMem[addr[3:0]] = b;
            mReg[rs] = addr;
         end
         OP_LD:    mReg[rt] = mMem[addr[3:0]];
         default: ;                                   // halt, nop, unsupported
      endcase
   endtask

   function automatic logic [15:0] rWord(input opcode_t op, input int rs, input int rt,
                                         input int rd, input int fn);
      return {op, 3'(rs), 3'(rt), 3'(rd), 2'(fn)};
   endfunction

   function automatic logic [15:0] iWord(input opcode_t op, input int rs, input int rd,
                                         input logic [4:0] imm);
      return {op, 3'(rs), 3'(rd), imm};
   endfunction

   task automatic issue(input logic [15:0] w);
      apbWrite(`WISC_ADDR_INSTR, {16'b0, w});
      modelExec(w);
   endtask

   task automatic loadReg(input int r, input logic [15:0] v);
      issue({OP_LBI, 3'(r), v[15:8]});
      issue({OP_SLBI, 3'(r), v[7:0]});
   endtask

   task automatic waitIdle();
      logic [31:0] st;
      int          polls;
      polls = 0;
      apbRead(`WISC_ADDR_STATUS, st);
      while (st[0]) begin
         polls++;
         if (polls > MAX_POLLS) abortRun("busy never dropped");
         apbRead(`WISC_ADDR_STATUS, st);
      end
   endtask

   task automatic checkStatus(input logic [2:0] expv);
      logic [31:0] st;
      apbRead(`WISC_ADDR_STATUS, st);
      checkValue("status", {29'b0, expv}, st);
   endtask

   task automatic checkRegs(input logic [15:0] expv [8]);
      logic [31:0] got;
      for (int n = 0; n < 8; n++) begin
         apbRead(8'(`WISC_ADDR_REG_BASE + 4 * n), got);
         checkValue($sformatf("r%0d", n), {16'b0, expv[n]}, got);
      end
   endtask

   task automatic checkSlvErr(input logic [7:0] addr, input logic wr);
      logic [31:0] rd;
      logic        se;
      apbXfer(addr, wr, '0, rd, se);
      checkValue($sformatf("pslverr@%h", addr), 1, se);
   endtask

   // full queue: a further instruction write must stall, then it is withdrawn
   task automatic probeStall(input logic [15:0] w);
      @(negedge clk);
      apb.psel    = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite  = 1'b1;
      apb.paddr   = `WISC_ADDR_INSTR;
      apb.pwdata  = {16'b0, w};
      @(negedge clk);
      apb.penable = 1'b1;
      for (int i = 0; i < STALL_WIN; i++) begin
         @(posedge clk);
         checkValue("pready", 0, pready);
      end
      @(negedge clk);
      apb.psel    = 1'b0;
      apb.penable = 1'b0;
   endtask

   task automatic randomAlu(input int count);
      logic [15:0] r;
      for (int i = 0; i < count; i++) begin
         r = lcgNext();
         case (r[1:0])
            2'b00:   issue(rWord(OP_ARITH, r[4:2], r[7:5], r[10:8], r[12:11]));
            2'b01:   issue(rWord(OP_SHIFT, r[4:2], r[7:5], r[10:8], r[12:11]));
            2'b10:   issue(iWord(opcode_t'({3'b010, r[12:11]}), r[4:2], r[7:5], r[15:11]));
            default: issue(iWord(opcode_t'({3'b101, r[12:11]}), r[4:2], r[7:5], r[15:11]));
         endcase
      end
   endtask

   task automatic startTest();
      errAtStart = errCnt;
   endtask

   task automatic endTest(input string name);
      testCnt++;
      $display("test %0d %s: %s", testCnt, name, (errCnt == errAtStart) ? "ok" : "errors");
   endtask

   initial begin
      logic [15:0] w;
      clk         = 1'b0;
      arstN       = 1'b0;
      apb         = '0;
      lcgState    = 32'd6;
      errCnt      = 0;
      checkCnt    = 0;
      testCnt     = 0;
      for (int i = 0; i < 8; i++) mReg[i] = '0;
      for (int i = 0; i < 16; i++) mMem[i] = '0;
      repeat (2) @(negedge clk);
      arstN = 1'b1;

      startTest();
      checkStatus(3'b000);
      checkRegs(mReg);
      endTest("reset state");

      startTest();
      for (int r = 0; r < 8; r++) loadReg(r, lcgNext());
      randomAlu(24);
      waitIdle();
      checkRegs(mReg);
      endTest("random alu");

      startTest();
      for (int pass = 0; pass < 2; pass++) begin
         if (pass == 0) begin
            loadReg(1, 16'h8000);                    // boundary operands
            loadReg(2, 16'h7fff);
            loadReg(3, 16'hffff);
            loadReg(4, 16'h0000);
         end else begin
            for (int r = 1; r < 5; r++) loadReg(r, lcgNext());
         end
         for (int s = 1; s < 5; s++) begin
            for (int t = 1; t < 5; t++) begin
               issue(rWord(OP_SEQ, s, t, 5, 0));
               issue(rWord(OP_SLT, s, t, 6, 0));
               issue(rWord(OP_SLE, s, t, 7, 0));
               issue(rWord(OP_SCO, s, t, 0, 0));
               waitIdle();
               checkRegs(mReg);
            end
            issue(rWord(OP_BTR, s, 0, 5, 0));
         end
         waitIdle();
         checkRegs(mReg);
      end
      endTest("set and bit reverse");

      startTest();
      for (int k = 0; k < 4; k++) begin
         loadReg(1, 16'(4 * k + 2));
         loadReg(2, lcgNext());
         loadReg(3, lcgNext());
         issue(iWord(OP_ST, 1, 2, 5'h1f));           // [r1-1] = r2
         issue(iWord(OP_LD, 1, 4, 5'h1f));
         issue(iWord(OP_STU, 1, 3, 5'h03));          // [r1+3] = r3, r1 = address
         issue(iWord(OP_LD, 1, 5, 5'h00));
         waitIdle();
         checkRegs(mReg);
      end
      endTest("store and load");

      startTest();
      issue({OP_HALT, 11'b0});
      waitIdle();
      checkStatus(3'b010);
      held = mReg;
      randomAlu(`WISC_QUEUE_DEPTH);
      checkStatus(3'b011);
      checkRegs(held);
      w = rWord(OP_ARITH, 1, 2, 3, 0);
      probeStall(w);
      apbWrite(`WISC_ADDR_CTRL, 32'h1);
      issue(w);
      waitIdle();
      checkStatus(3'b000);
      checkRegs(mReg);
      endTest("halt and back-pressure");

      startTest();
      held = mReg;
      issue({OP_J, 11'h155});
      waitIdle();
      checkStatus(3'b100);
      checkRegs(held);
      checkSlvErr(8'h10, 1'b0);
      checkSlvErr(8'h40, 1'b0);                      // register index 8
      checkSlvErr(`WISC_ADDR_INSTR, 1'b0);
      checkSlvErr(`WISC_ADDR_STATUS, 1'b1);
      apbWrite(`WISC_ADDR_CTRL, 32'h1);
      checkStatus(3'b000);
      endTest("unsupported word and bad address");

      $display("tests %0d, checks %0d, errors %0d", testCnt, checkCnt, errCnt);
      if (errCnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: wiscCore.f
+incdir+verilog
verilog/wiscPkg.sv
verilog/instrApbPort.sv
verilog/instrQueue.sv
verilog/controlUnit.sv
verilog/execUnit.sv
verilog/wiscCore.sv
sim/wiscCoreTb.sv

// File: Makefile
# Verilator build and run of the WISC execution subsystem testbench

VERILATOR ?= verilator
TOP       ?= wiscCoreTb
FILELIST  ?= wiscCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
